// File: common/mag_pkg.sv
/*
  Shared sizes and types for the complex magnitude front end.
  Imported by every RTL block that handles samples, beats or magnitudes.
  A beat is four complex channels, each with Q in the upper half and I
  in the lower half of a 32-bit word.
*/

package mag_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  // complex samples per input beat
  localparam int num_channels = 4;

  // width of one I or Q component
  localparam int sample_width = 16;

  // max plus half of min never exceeds 1.5 * 2^15
  localparam int mag_width = sample_width + 1;

  // stages in cabs_approx
  localparam int cabs_latency = 3;

  localparam int chan_width = $clog2(num_channels);

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic signed [sample_width-1:0] sample_t;

  // {q, i}
  typedef logic [2*sample_width-1:0] cplx_t;

  typedef cplx_t [num_channels-1:0] beat_t;

  typedef logic [mag_width-1:0] mag_t;

  typedef mag_t [num_channels-1:0] mag_beat_t;

  typedef logic [chan_width-1:0] chan_t;

endpackage

// File: src/delay_line.sv
/*
  Fixed-depth register chain for any packed payload.
  Every stage clears to zero on reset, so valid bits carried in the
  payload come out inactive until real data has passed through.
*/

`timescale 1ns/10ps

module delay_line #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t din,
  output payload_t dout
);

  payload_t stage [depth];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      // shift toward the output end
      for (int i = 1; i < depth; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[depth-1];

endmodule

// File: cabs/cabs_approx.sv
/*
  Alpha-max-plus-beta-min magnitude of one complex sample.
  mag = max(|re|, |im|) + floor(min(|re|, |im|) / 2), three stages deep.
  Free running: a new sample may enter every cycle, no valid is carried.
*/

`timescale 1ns/10ps

module cabs_approx (
  input  logic             clk,
  input  mag_pkg::sample_t re,
  input  mag_pkg::sample_t im,
  output mag_pkg::mag_t    mag
);

  import mag_pkg::*;

  // one extra bit so that -2^15 negates cleanly
  logic signed [sample_width:0] re_ext;
  logic signed [sample_width:0] im_ext;

  mag_t abs_re;
  mag_t abs_im;
  mag_t max_val;
  mag_t min_val;
  mag_t mag_reg;

  assign re_ext = re;
  assign im_ext = im;

  //////////////////////////////////////////////////
  // stage 1 takes absolute values
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    abs_re <= re_ext[sample_width] ? mag_t'(-re_ext) : mag_t'(re_ext);
    abs_im <= im_ext[sample_width] ? mag_t'(-im_ext) : mag_t'(im_ext);
  end

  //////////////////////////////////////////////////
  // stage 2 sorts into max and min
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (abs_re >= abs_im) begin
      max_val <= abs_re;
      min_val <= abs_im;
    end else begin
      max_val <= abs_im;
      min_val <= abs_re;
    end
  end

  //////////////////////////////////////////////////
  // stage 3 adds max and half min
  //////////////////////////////////////////////////

  // half of min is truncated
  always_ff @(posedge clk) begin
    mag_reg <= max_val + (min_val >> 1);
  end

  assign mag = mag_reg;

endmodule

// File: cabs/cabs_serial.sv
/*
  Serial magnitude engine for a four-channel beat.
  Walks the channels of the held input beat one per cycle through a
  shared cabs_approx, collects the results, and strobes the beat out
  together with its magnitudes 5 edges after the accepting edge.
*/

`timescale 1ns/10ps

module cabs_serial (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  mag_pkg::beat_t      in_data,
  output logic                beat_valid,
  output mag_pkg::beat_t      beat_data,
  output mag_pkg::mag_beat_t  beat_mag
);

  import mag_pkg::*;

  // {channel index, sample valid}
  typedef logic [chan_width:0] tag_t;

  // {beat, accept flag}
  typedef logic [$bits(beat_t):0] held_t;

  chan_t     count;
  logic      accept;
  cplx_t     cur_sample;
  mag_t      cabs_mag;

  tag_t      tag_in;
  tag_t      tag_out;
  chan_t     tag_chan;
  logic      tag_valid;

  held_t     held_in;
  held_t     held_out;
  beat_t     held_beat;
  logic      held_accept;

  mag_t      mag_mem [num_channels];
  mag_beat_t mem_beat;

  //////////////////////////////////////////////////
  // input handshake and channel counter
  //////////////////////////////////////////////////

  // the beat is taken on its last channel
  assign in_ready = (count == chan_t'(num_channels - 1));
  assign accept   = in_valid & in_ready;

  // frozen while in_valid is low
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (in_valid) begin
      if (count == chan_t'(num_channels - 1)) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // shared magnitude pipe
  //////////////////////////////////////////////////

  assign cur_sample = in_data[count];

  cabs_approx cabs_approx_inst (
    .clk (clk),
    .re  (cur_sample[sample_width-1:0]),
    .im  (cur_sample[2*sample_width-1:sample_width]),
    .mag (cabs_mag)
  );

  // channel tag runs beside the pipe
  assign tag_in = {count, in_valid};

  delay_line #(
    .payload_t (tag_t),
    .depth     (cabs_latency)
  ) tag_delay_inst (
    .clk  (clk),
    .rst  (rst),
    .din  (tag_in),
    .dout (tag_out)
  );

  assign {tag_chan, tag_valid} = tag_out;

  // one slot per channel
  always_ff @(posedge clk) begin
    if (tag_valid) begin
      mag_mem[tag_chan] <= cabs_mag;
    end
  end

  always_comb begin
    for (int i = 0; i < num_channels; i++) begin
      mem_beat[i] = mag_mem[i];
    end
  end

  //////////////////////////////////////////////////
  // beat alignment and output register
  //////////////////////////////////////////////////

  // one edge longer than the pipe, to cover the memory write
  assign held_in = {in_data, accept};

  delay_line #(
    .payload_t (held_t),
    .depth     (cabs_latency + 1)
  ) beat_delay_inst (
    .clk  (clk),
    .rst  (rst),
    .din  (held_in),
    .dout (held_out)
  );

  assign {held_beat, held_accept} = held_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= held_accept;
    end
  end

  always_ff @(posedge clk) begin
    beat_data <= held_beat;
    beat_mag  <= mem_beat;
  end

endmodule

// File: src/peak_pick.sv
/*
  Strongest-channel search over one beat of magnitudes.
  Lowest index wins a tie. peak_hit is set when the peak reaches the
  threshold. Adds one register stage; the beat and magnitudes pass along.
*/

`timescale 1ns/10ps

module peak_pick (
  input  logic               clk,
  input  logic               rst,
  input  mag_pkg::mag_t      threshold,
  input  logic               beat_valid,
  input  mag_pkg::beat_t     beat_data,
  input  mag_pkg::mag_beat_t beat_mag,
  output logic               out_valid,
  output mag_pkg::beat_t     out_data,
  output mag_pkg::mag_beat_t out_mag,
  output mag_pkg::chan_t     peak_chan,
  output mag_pkg::mag_t      peak_mag,
  output logic               peak_hit
);

  import mag_pkg::*;

  chan_t best_chan;
  mag_t  best_mag;

  // strict compare keeps the earlier channel on a tie
  always_comb begin
    best_chan = '0;
    best_mag  = beat_mag[0];
    for (int i = 1; i < num_channels; i++) begin
      if (beat_mag[i] > best_mag) begin
        best_chan = chan_t'(i);
        best_mag  = beat_mag[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= beat_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_data  <= beat_data;
    out_mag   <= beat_mag;
    peak_chan <= best_chan;
    peak_mag  <= best_mag;
    peak_hit  <= (best_mag >= threshold);
  end

endmodule

// File: src/mag_frontend_top.sv
/*
  Complex magnitude front end.
  Beats enter through a valid/ready port, at most one every four cycles;
  results leave on a one-cycle out_valid strobe 6 edges after acceptance.
*/

`timescale 1ns/10ps

module mag_frontend_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  mag_pkg::beat_t     in_data,
  input  mag_pkg::mag_t      threshold,
  output logic               out_valid,
  output mag_pkg::beat_t     out_data,
  output mag_pkg::mag_beat_t out_mag,
  output mag_pkg::chan_t     peak_chan,
  output mag_pkg::mag_t      peak_mag,
  output logic               peak_hit
);

  import mag_pkg::*;

  // cabs_serial to peak_pick
  logic      beat_valid;
  beat_t     beat_data;
  mag_beat_t beat_mag;

  cabs_serial cabs_serial_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_mag   (beat_mag)
  );

  peak_pick peak_pick_inst (
    .clk        (clk),
    .rst        (rst),
    .threshold  (threshold),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_mag   (beat_mag),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_mag    (out_mag),
    .peak_chan  (peak_chan),
    .peak_mag   (peak_mag),
    .peak_hit   (peak_hit)
  );

endmodule

// File: dv/cabs_serial_props.sv
/*
  Handshake and strobe assertions for the serial magnitude engine.
  Bound into every cabs_serial instance.
*/

`timescale 1ns/10ps

module cabs_serial_props (
  input logic           clk,
  input logic           rst,
  input logic           in_valid,
  input logic           in_ready,
  input mag_pkg::beat_t in_data,
  input logic           beat_valid
);

  // a pending beat must not change under the engine
  hold_pending: assert property (@(posedge clk) disable iff (rst)
    (in_valid && !in_ready) |=> $stable(in_data))
    else $error("in_data changed while a beat was pending");

  single_strobe: assert property (@(posedge clk) disable iff (rst)
    beat_valid |=> !beat_valid)
    else $error("beat_valid high on two cycles in a row");

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!in_ready && !beat_valid))
    else $error("in_ready or beat_valid high right after reset");

endmodule

bind cabs_serial cabs_serial_props cabs_serial_props_inst (
  .clk        (clk),
  .rst        (rst),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .in_data    (in_data),
  .beat_valid (beat_valid)
);

// File: dv/tb_top.sv
/*
  Testbench for the complex magnitude front end.
  Sends random beats through the valid/ready port, predicts every result
  from the magnitude and peak rules, and checks the strobed outputs and
  their timing. The run stops at the first mismatch.
*/

`timescale 1ns/10ps

module tb_top;

  import mag_pkg::*;

  localparam int num_beats     = 400;
  // falling edges from driving an accepted beat to seeing its result
  localparam int out_latency   = 6;
  localparam int cycle_limit   = num_beats * num_channels * 2 + 100;
  localparam int thresh_period = 50;

  typedef struct packed {
    beat_t     beat;
    mag_beat_t mags;
    chan_t     chan;
    mag_t      peak;
    logic      hit;
    int        due;
  } expect_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  beat_t     in_data;
  mag_t      threshold;
  logic      out_valid;
  beat_t     out_data;
  mag_beat_t out_mag;
  chan_t     peak_chan;
  mag_t      peak_mag;
  logic      peak_hit;

  integer    seed;
  int        cyc = 0;
  int        run_cycles = 0;
  int        exp_count = 0;
  expect_t   exp_q [$];

  // 0 always hits and the all-ones value never does
  // 49152 is the largest possible magnitude
  mag_t      thresh_values [8] = '{17'd0, 17'h1ffff, 17'd49152, 17'd32768,
                                   17'd16384, 17'd24000, 17'd1, 17'd40000};

  mag_frontend_top mag_frontend_top_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .threshold (threshold),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_mag   (out_mag),
    .peak_chan (peak_chan),
    .peak_mag  (peak_mag),
    .peak_hit  (peak_hit)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    run_cycles = run_cycles + 1;
    if (run_cycles > cycle_limit) begin
      fail_now($sformatf("timeout: run passed %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////////////////////////
  // failure and compare tasks
  //////////////////////////////////////////////////

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_mag_beat(input string name, input mag_beat_t exp, input mag_beat_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_mag(input string name, input mag_t exp, input mag_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_chan(input string name, input chan_t exp, input chan_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // max of |i|, |q| plus half the smaller, half truncated
  function automatic mag_t model_mag(input cplx_t c);
    sample_t s_i;
    sample_t s_q;
    int      a_i;
    int      a_q;
    s_i = c[sample_width-1:0];
    s_q = c[2*sample_width-1:sample_width];
    a_i = (s_i < 0) ? -int'(s_i) : int'(s_i);
    a_q = (s_q < 0) ? -int'(s_q) : int'(s_q);
    if (a_i >= a_q) begin
      return mag_t'(a_i + a_q / 2);
    end else begin
      return mag_t'(a_q + a_i / 2);
    end
  endfunction

  task automatic push_expected(input beat_t b, input int due);
    expect_t e;
    e.beat = b;
    for (int i = 0; i < num_channels; i++) begin
      e.mags[i] = model_mag(b[i]);
    end
    // largest magnitude, then the lowest channel that holds it
    e.peak = e.mags[0];
    for (int i = 1; i < num_channels; i++) begin
      if (e.mags[i] > e.peak) begin
        e.peak = e.mags[i];
      end
    end
    e.chan = '0;
    for (int i = num_channels - 1; i >= 0; i--) begin
      if (e.mags[i] == e.peak) begin
        e.chan = chan_t'(i);
      end
    end
    e.hit = (e.peak >= threshold);
    e.due = due;
    exp_q.push_back(e);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic make_sample(output sample_t s);
    int sel;
    sel = $random(seed) & 15;
    case (sel)
      0:       s = sample_t'(16'h7fff);
      1:       s = sample_t'(16'h8000);
      2:       s = '0;
      default: s = sample_t'($random(seed));
    endcase
  endtask

  task automatic make_beat(output beat_t b);
    sample_t s_i;
    sample_t s_q;
    for (int i = 0; i < num_channels; i++) begin
      make_sample(s_i);
      make_sample(s_q);
      b[i] = {s_q, s_i};
    end
    // swapped copies of channel 0 have equal magnitudes and force ties
    if (($random(seed) & 7) == 0) begin
      for (int i = 1; i < num_channels; i++) begin
        if ($random(seed) & 1) begin
          b[i] = {b[0][sample_width-1:0], b[0][2*sample_width-1:sample_width]};
        end
      end
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    logic    due;
    if (out_valid && exp_q.size() == 0) begin
      fail_now("out_valid went high with no accepted beat outstanding");
    end else begin
      due = (exp_q.size() != 0) && (exp_q[0].due == cyc);
      check_bit("out_valid", due, out_valid);
      if (due) begin
        e = exp_q.pop_front();
        check_beat("out_data", e.beat, out_data);
        check_mag_beat("out_mag", e.mags, out_mag);
        check_chan("peak_chan", e.chan, peak_chan);
        check_mag("peak_mag", e.peak, peak_mag);
        check_bit("peak_hit", e.hit, peak_hit);
      end
    end
  endtask

  // outputs are settled at the falling edge
  task automatic next_cycle();
    @(negedge clk);
    cyc++;
    check_bit("in_ready", exp_count == num_channels - 1, in_ready);
    check_outputs();
  endtask

  // hold the beat, with random gaps in in_valid, until it is taken
  task automatic send_beat(input beat_t b);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      next_cycle();
      in_data  = b;
      in_valid = (($random(seed) & 3) != 0);
      if (in_valid && in_ready) begin
        push_expected(b, cyc + out_latency);
        taken = 1'b1;
      end
      if (in_valid) begin
        exp_count = (exp_count + 1) % num_channels;
      end
    end
  endtask

  task automatic drain_pipeline();
    do begin
      next_cycle();
      in_valid = 1'b0;
    end while (exp_q.size() != 0);
  endtask

  initial begin
    beat_t beat;
    seed      = 30637;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    threshold = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int n = 0; n < num_beats; n++) begin
      // threshold moves only with an empty pipeline
      if (n % thresh_period == 0) begin
        drain_pipeline();
        threshold = thresh_values[n / thresh_period];
      end
      make_beat(beat);
      send_beat(beat);
    end
    drain_pipeline();

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: build.f
common/mag_pkg.sv
src/delay_line.sv
cabs/cabs_approx.sv
cabs/cabs_serial.sv
src/peak_pick.sv
src/mag_frontend_top.sv
dv/cabs_serial_props.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the magnitude front end testbench with Verilator.
# Exit status is 0 only when the pass line shows up in the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
  -f build.f -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see build.log"
  exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -qx "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi
